// File: verilog.f
+incdir+bench
common/soc_pkg.sv
source/lsu_decoder.sv
data_memory/data_memory.sv
gpio/gpio_controller.sv
source/response_merge.sv
source/lsu_fabric_top.sv
bench/lsu_fabric_tb.sv

// File: bench/lsu_fabric_model.svh
`ifndef lsu_fabric_model_svh
`define lsu_fabric_model_svh

////////////////////////////////////////
// model state
////////////////////////////////////////

// memory image, words never written stay unknown like the array
word_t       mdl_mem [lsm_words];
// gpio registers and the level held on the pins
gpio_t       mdl_out = '0;
gpio_t       mdl_ena = '0;
gpio_t       mdl_pins = '0;
logic [31:0] lcg_state = 32'd12680;

// next pseudo random word, halves swapped since low lcg bits are weak
function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return {lcg_state[15:0], lcg_state[31:16]};
endfunction

// old word with the enabled bytes replaced
function automatic word_t merge_bytes(input word_t old, input word_t wdt, input ben_t ben);
  word_t w;
  w = old;
  for (int b = 0; b < blen; b++) begin
    if (ben[b]) begin
      w[8*b +: 8] = wdt[8*b +: 8];
    end
  end
  return w;
endfunction

// expected response, model state follows the request
function automatic tcb_rsp_t ref_rsp(input tcb_req_t r);
  tcb_rsp_t e;
  int       low;
  e = '{vld: 1'b1, rdt: '0, err: 1'b0};
  low = -1;
  for (int i = blen-1; i >= 0; i--) begin
    if (r.ben[i]) begin
      low = i;
    end
  end
  if (low < 0 || low != int'(r.adr[1:0])) begin
    // misaligned, nothing changes
    e.err = 1'b1;
  end else if (!r.adr[per_bit]) begin
    // read-first
    e.rdt = mdl_mem[r.adr[lsm_adr-1:2]];
    if (r.wen) begin
      mdl_mem[r.adr[lsm_adr-1:2]] = merge_bytes(e.rdt, r.wdt, r.ben);
    end
  end else if (r.adr[uart_bit]) begin
    e.err = 1'b1;
  end else begin
    case (r.adr[3:2])
      gpio_reg_out: e.rdt = mdl_out;
      gpio_reg_ena: e.rdt = mdl_ena;
      gpio_reg_in:  e.rdt = mdl_pins;
      default:      e.rdt = '0;
    endcase
    if (r.wen && r.adr[3:2] == gpio_reg_out) begin
      mdl_out = merge_bytes(mdl_out, r.wdt, r.ben);
    end
    if (r.wen && r.adr[3:2] == gpio_reg_ena) begin
      mdl_ena = merge_bytes(mdl_ena, r.wdt, r.ben);
    end
  end
  return e;
endfunction

`endif

// File: bench/lsu_fabric_tb.sv
`timescale 1ns/10ps

module lsu_fabric_tb
  import soc_pkg::*;
();

  // request counts per part of the run
  localparam int n_words = 64;
  localparam int n_part = 48;
  localparam int n_stream = 200;
  localparam int n_fixed = 40;
  localparam int n_requests = 2*n_words + n_part + n_stream + n_fixed;
  localparam int watchdog_ns = n_requests*10*4 + 3*10;

  logic     clk;
  logic     rst_n;
  tcb_req_t req;
  tcb_rsp_t rsp;
  gpio_t    gpio_i;
  gpio_t    gpio_o;
  gpio_t    gpio_e;
  // bookkeeping
  int       n_req = 0;
  int       n_rsp = 0;
  int       n_chk = 0;
  int       n_err = 0;
  int       n_tests = 0;
  int       n_failed = 0;
  int       err_mark = 0;
  string    test_name;

  `include "lsu_fabric_model.svh"

  lsu_fabric_top uut (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .rsp    (rsp),
    .gpio_i (gpio_i),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, responses stopped coming", watchdog_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_rsp(input tcb_rsp_t got, input tcb_rsp_t exp, input logic rd);
    n_chk++;
    if (got.vld !== 1'b1) begin
      $display("no response one cycle after the request at %0t", $time);
      n_err++;
    end else if (got.err !== exp.err) begin
      $display("FAILED rsp.err got %h exp %h", got.err, exp.err);
      n_err++;
    end else if (rd && got.rdt !== exp.rdt) begin
      // data only on error-free reads
      $display("FAILED rsp.rdt got %h exp %h", got.rdt, exp.rdt);
      n_err++;
    end
  endtask

  task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp);
    n_chk++;
    if (got !== exp) begin
      $display("FAILED %s got %h exp %h", name, got, exp);
      n_err++;
    end
  endtask

  // response of a request is due at the negedge one cycle after it
  initial begin : compare
    logic     pend;
    logic     exp_rd;
    tcb_rsp_t exp;
    pend = 1'b0;
    forever begin
      @(negedge clk);
      if (pend) begin
        check_rsp(rsp, exp, exp_rd);
        check_gpio("gpio_o", gpio_o, mdl_out);
        check_gpio("gpio_e", gpio_e, mdl_ena);
        n_rsp++;
      end else if (rst_n && rsp.vld !== 1'b0) begin
        $display("response seen with no request in flight at %0t", $time);
        n_err++;
      end
      // request the DUT takes at the next edge
      pend = rst_n && req.vld === 1'b1;
      if (pend) begin
        exp = ref_rsp(req);
        exp_rd = !req.wen && !exp.err;
        n_req++;
      end
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task automatic send_req(input logic wen, input adr_t adr, input ben_t ben, input word_t wdt);
    tcb_req_t r;
    r = '{vld: 1'b1, wen: wen, adr: adr, ben: ben, wdt: wdt};
    @(posedge clk);
    req <= r;
  endtask

  // no request, then wait until every response was checked
  task automatic drain();
    @(posedge clk);
    req.vld <= 1'b0;
    while (n_rsp != n_req) @(posedge clk);
  endtask

  // idle bus while the pins change
  task automatic set_pins(input gpio_t v);
    @(posedge clk);
    req.vld <= 1'b0;
    gpio_i <= v;
    mdl_pins = v;
  endtask

  // random legal size and offset: byte, half or word
  task automatic random_lane(output logic [1:0] off, output ben_t ben);
    logic [31:0] r;
    r = lcg_next();
    case (r[1:0])
      2'd0:    off = r[3:2];
      2'd1:    off = {r[3], 1'b0};
      default: off = 2'd0;
    endcase
    ben = (r[1:0] == 2'd0) ? ben_t'(1) << off : (r[1:0] == 2'd1) ? ben_t'(3) << off : 4'hf;
  endtask

  // memory window of n_words words, junk in the ignored upper bits
  function automatic adr_t mem_adr(input logic [5:0] widx, input logic [1:0] off);
    logic [31:0] hi;
    hi = lcg_next();
    return {hi[31:15], 7'd0, widx, off};
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    err_mark = n_err;
  endtask

  task automatic finish_test();
    drain();
    n_tests++;
    if (n_err == err_mark) begin
      $display("test %0d %s: ok", n_tests, test_name);
    end else begin
      n_failed++;
      $display("test %0d %s: %0d errors", n_tests, test_name, n_err - err_mark);
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  initial begin
    logic [1:0]  off;
    ben_t        ben;
    logic [31:0] r;
    adr_t        adr;
    rst_n = 1'b0;
    req = '0;
    gpio_i = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    start_test("reset values");
    @(negedge clk);
    check_gpio("gpio_o", gpio_o, '0);
    check_gpio("gpio_e", gpio_e, '0);
    n_chk++;
    if (rsp.vld !== 1'b0) begin
      $display("FAILED rsp.vld got %h exp 0", rsp.vld);
      n_err++;
    end
    finish_test();

    start_test("memory write and read");
    for (int i = 0; i < n_words; i++) send_req(1'b1, mem_adr(6'(i), 2'd0), 4'hf, lcg_next());
    for (int i = 0; i < n_part; i++) begin
      random_lane(off, ben);
      r = lcg_next();
      send_req(1'b1, mem_adr(r[5:0], off), ben, lcg_next());
    end
    for (int i = 0; i < n_words; i++) send_req(1'b0, mem_adr(6'(i), 2'd0), 4'hf, '0);
    finish_test();

    start_test("gpio output and enable");
    send_req(1'b1, 32'h0000_4000, 4'hf, 32'ha5c3_0f81);
    send_req(1'b1, 32'h0000_4004, 4'hf, 32'h0000_ffff);
    send_req(1'b0, 32'h0000_4000, 4'hf, '0);
    send_req(1'b0, 32'h0000_4004, 4'hf, '0);
    // upper half only
    send_req(1'b1, 32'h0000_4002, 4'b1100, 32'h1234_0000);
    send_req(1'b0, 32'h0000_4000, 4'hf, '0);
    // slot 3 is not a register
    send_req(1'b1, 32'h0000_400c, 4'hf, 32'hdead_beef);
    send_req(1'b0, 32'h0000_400c, 4'hf, '0);
    drain();
    check_gpio("gpio_o", gpio_o, 32'h1234_0f81);
    check_gpio("gpio_e", gpio_e, 32'h0000_ffff);
    finish_test();

    start_test("gpio input pins");
    set_pins(32'h1357_9bdf);
    repeat (3) @(posedge clk);
    send_req(1'b0, 32'h0000_4008, 4'hf, '0);
    set_pins(32'hfedc_ba98);
    repeat (3) @(posedge clk);
    send_req(1'b0, 32'h0000_400a, 4'b1100, '0);
    finish_test();

    start_test("uart window and misaligned");
    send_req(1'b0, 32'h0000_4040, 4'hf, '0);
    send_req(1'b1, 32'hffff_c044, 4'hf, 32'h5555_aaaa);
    // offset 1 but lowest byte enabled is 0
    send_req(1'b1, 32'h0000_0011, 4'b0001, 32'hffff_ffff);
    send_req(1'b1, 32'h0000_0010, 4'b0000, 32'hffff_ffff);
    send_req(1'b0, 32'h0000_0012, 4'b0011, '0);
    // word 4 must still hold its old value
    send_req(1'b0, 32'h0000_0010, 4'hf, '0);
    finish_test();

    start_test("mixed back-to-back stream");
    for (int i = 0; i < n_stream; i++) begin
      r = lcg_next();
      random_lane(off, ben);
      adr = mem_adr(r[13:8], off);
      case (r[2:0])
        3'd5:    adr = {adr[31:15], 1'b1, 10'd0, r[9:8], off};
        3'd6:    adr = {adr[31:15], 1'b1, 7'd0, 1'b1, r[11:8], off};
        3'd7: begin
          // arbitrary lanes, mostly misaligned
          adr = mem_adr(r[13:8], r[17:16]);
          ben = r[23:20];
        end
        default: ;
      endcase
      send_req(r[24], adr, ben, lcg_next());
    end
    finish_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed, n_chk, n_err);
    if (n_err == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule: lsu_fabric_tb

// File: source/lsu_fabric_top.sv
`timescale 1ns/10ps

module lsu_fabric_top
  import soc_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  tcb_req_t req,
  output tcb_rsp_t rsp,
  input  gpio_t    gpio_i,
  output gpio_t    gpio_o,
  output gpio_t    gpio_e
);

  // per-target strobes from the decoder
  logic    mem_sel;
  logic    gpio_sel;
  target_e tgt;
  // registered read data from each target
  word_t   mem_rdt;
  word_t   gpio_rdt;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  lsu_decoder dec (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .mem_sel  (mem_sel),
    .gpio_sel (gpio_sel),
    .tgt      (tgt)
  );

  ////////////////////////////////////////
  // targets
  ////////////////////////////////////////

  data_memory dmem (
    .clk (clk),
    .req (req),
    .sel (mem_sel),
    .rdt (mem_rdt)
  );

  gpio_controller gpio (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .sel    (gpio_sel),
    .gpio_i (gpio_i),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .rdt    (gpio_rdt)
  );

  // response merge, one cycle after request
  response_merge merge (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_vld  (req.vld),
    .tgt      (tgt),
    .mem_rdt  (mem_rdt),
    .gpio_rdt (gpio_rdt),
    .rsp      (rsp)
  );

endmodule: lsu_fabric_top

// File: source/response_merge.sv
`timescale 1ns/10ps

module response_merge
  import soc_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_vld,
  input  target_e  tgt,
  input  word_t    mem_rdt,
  input  word_t    gpio_rdt,
  output tcb_rsp_t rsp
);

  ////////////////////////////////////////
  // request in flight
  ////////////////////////////////////////

  // valid and target of last cycle's request
  logic    vld_q;
  target_e tgt_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
      tgt_q <= tgt_mem;
    end else begin
      vld_q <= req_vld;
      // keep last target when idle
      if (req_vld) begin
        tgt_q <= tgt;
      end
    end
  end

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  always_comb begin
    rsp.vld = vld_q;
    // data source follows the target
    case (tgt_q)
      tgt_mem:  rsp.rdt = mem_rdt;
      tgt_gpio: rsp.rdt = gpio_rdt;
      // uart and misaligned carry no data
      default:  rsp.rdt = '0;
    endcase
    // error for uart window and bad alignment
    rsp.err = vld_q && ((tgt_q == tgt_uart) || (tgt_q == tgt_err));
  end

  // a request always names a known target
  assert property (@(posedge clk) disable iff (!rst_n) req_vld |-> !$isunknown(tgt));

endmodule: response_merge

// File: gpio/gpio_controller.sv
`timescale 1ns/10ps

module gpio_controller
  import soc_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  tcb_req_t req,
  input  logic     sel,
  input  gpio_t    gpio_i,
  output gpio_t    gpio_o,
  output gpio_t    gpio_e,
  output word_t    rdt
);

  // register index from address bits 3:2
  logic [gpio_idx_w-1:0] idx;
  // register write strobe
  logic                  wr;
  // input synchronizer stages
  gpio_t                 sync_q1;
  gpio_t                 sync_q2;
  // read mux before the response register
  word_t                 rd_mux;

  assign idx = req.adr[blog +: gpio_idx_w];
  assign wr  = sel && req.wen;

  ////////////////////////////////////////
  // output and enable registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (wr) begin
      for (int b = 0; b < blen; b++) begin
        if (req.ben[b]) begin
          // input register and index 3 take no writes
          case (idx)
            gpio_reg_out: gpio_o[8*b +: 8] <= req.wdt[8*b +: 8];
            gpio_reg_ena: gpio_e[8*b +: 8] <= req.wdt[8*b +: 8];
            default: ;
          endcase
        end
      end
    end
  end

  ////////////////////////////////////////
  // input synchronizer
  ////////////////////////////////////////

  // two flops, pin visible to reads after 2 edges
  always_ff @(posedge clk) begin
    sync_q1 <= gpio_i;
    sync_q2 <= sync_q1;
  end

  ////////////////////////////////////////
  // read response
  ////////////////////////////////////////

  always_comb begin
    case (idx)
      gpio_reg_out: rd_mux = word_t'(gpio_o);
      gpio_reg_ena: rd_mux = word_t'(gpio_e);
      gpio_reg_in:  rd_mux = word_t'(sync_q2);
      // unmapped slot reads zero
      default:      rd_mux = '0;
    endcase
  end

  // registered, so gpio answers with memory latency
  always_ff @(posedge clk) begin
    if (sel) begin
      rdt <= rd_mux;
    end
  end

  // pins are driven to known levels once out of reset
  assert property (@(posedge clk) disable iff (!rst_n) !$isunknown({gpio_o, gpio_e}));

endmodule: gpio_controller

// File: data_memory/data_memory.sv
`timescale 1ns/10ps

module data_memory
  import soc_pkg::*;
(
  input  logic     clk,
  input  tcb_req_t req,
  input  logic     sel,
  output word_t    rdt
);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // 4096 words, contents undefined after reset
  word_t mem [lsm_words];

  // word index from the byte address
  logic [lsm_adr-blog-1:0] idx;

  // upper address bits are ignored
  assign idx = req.adr[lsm_adr-1:blog];

  ////////////////////////////////////////
  // access
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (sel) begin
      if (req.wen) begin
        // only enabled bytes change
        for (int b = 0; b < blen; b++) begin
          if (req.ben[b]) begin
            mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
          end
        end
      end
      // read-first, old word on a write
      rdt <= mem[idx];
    end
  end

endmodule: data_memory

// File: source/lsu_decoder.sv
`timescale 1ns/10ps

module lsu_decoder
  import soc_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  tcb_req_t req,
  output logic     mem_sel,
  output logic     gpio_sel,
  output target_e  tgt
);

  ////////////////////////////////////////
  // alignment
  ////////////////////////////////////////

  // index of the lowest enabled byte
  logic [blog-1:0] low_idx;
  logic            aligned;

  always_comb begin
    low_idx = '0;
    // scan down so the lowest set bit wins
    for (int i = blen-1; i >= 0; i--) begin
      if (req.ben[i]) begin
        low_idx = blog'(i);
      end
    end
  end

  // at least one byte and the first one on the address offset
  assign aligned = (|req.ben) && (low_idx == req.adr[blog-1:0]);

  ////////////////////////////////////////
  // address classification
  ////////////////////////////////////////

  always_comb begin
    if (!aligned) begin
      tgt = tgt_err;
    end else if (!req.adr[per_bit]) begin
      tgt = tgt_mem;
    end else if (req.adr[uart_bit]) begin
      // uart window has no controller behind it
      tgt = tgt_uart;
    end else begin
      tgt = tgt_gpio;
    end
  end

  // strobes only in the request cycle
  assign mem_sel  = req.vld && (tgt == tgt_mem);
  assign gpio_sel = req.vld && (tgt == tgt_gpio);

  // a strobe needs the addressed byte enabled and no enabled byte below it
  assert property (@(posedge clk) disable iff (!rst_n)
    (mem_sel || gpio_sel) |->
      (req.ben[req.adr[blog-1:0]] &&
       ((req.ben & ((ben_t'(1) << req.adr[blog-1:0]) - ben_t'(1))) == '0)));

endmodule: lsu_decoder

// File: common/soc_pkg.sv
package soc_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  // data word width
  localparam int unsigned xlen = 32;
  // bytes per word
  localparam int unsigned blen = xlen/8;
  // byte offset width inside a word
  localparam int unsigned blog = $clog2(blen);
  // gpio pin count, same as a data word
  localparam int unsigned gw = 32;

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  // data memory byte address width, 16 KiB
  localparam int unsigned lsm_adr = 14;
  // number of words in data memory
  localparam int unsigned lsm_words = 2**(lsm_adr-blog);
  // high half of the map holds peripherals
  localparam int unsigned per_bit = 14;
  // inside peripherals, uart window vs gpio
  localparam int unsigned uart_bit = 6;

  // gpio register index, address bits 3:2
  localparam int unsigned gpio_idx_w = 2;
  localparam logic [gpio_idx_w-1:0] gpio_reg_out = 2'd0;
  localparam logic [gpio_idx_w-1:0] gpio_reg_ena = 2'd1;
  localparam logic [gpio_idx_w-1:0] gpio_reg_in = 2'd2;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef logic [xlen-1:0] word_t;
  typedef logic [blen-1:0] ben_t;
  typedef logic [xlen-1:0] adr_t;
  typedef logic [gw-1:0]   gpio_t;

  // request, already in memory byte packing
  typedef struct packed {
    logic  vld;
    logic  wen;
    adr_t  adr;
    ben_t  ben;
    word_t wdt;
  } tcb_req_t;

  // response, one cycle after the request
  typedef struct packed {
    logic  vld;
    word_t rdt;
    logic  err;
  } tcb_rsp_t;

  // routing target of a request
  typedef enum logic [1:0] {
    tgt_mem  = 2'd0,
    tgt_gpio = 2'd1,
    tgt_uart = 2'd2,
    // misaligned access
    tgt_err  = 2'd3
  } target_e;

endpackage: soc_pkg
